//--- axi_interconnect.sv
`timescale 1ns/10ps

module axi_interconnect
    import axi_lite_pkg::*;
(
    input  logic          aclk,
    input  logic          aresetn,
    input  axi_lite_req_t m1_req,
    output axi_lite_rsp_t m1_rsp,
    input  axi_lite_req_t m2_req,
    output axi_lite_rsp_t m2_rsp,
    output axi_lite_req_t s_req,
    input  axi_lite_rsp_t s_rsp
);

    grant_state_t state;
    grant_state_t next_state;

    logic m1_rd_req;
    logic m1_wr_req;
    logic m2_rd_req;
    logic m2_wr_req;

    logic m1_sel;
    logic m2_sel;
    logic rd_sel;
    logic wr_sel;
    logic rd_done;
    logic wr_done;

    axi_lite_req_t src_req;   // request of the granted master.
    axi_lite_rsp_t back_rsp;  // slave response, masked to the granted direction.

    // keep only the read address and read data channels of a request.
    function automatic axi_lite_req_t req_read(input axi_lite_req_t r);
        axi_lite_req_t o;
        o         = '0;
        o.araddr  = r.araddr;
        o.arprot  = r.arprot;
        o.arvalid = r.arvalid;
        o.rready  = r.rready;
        return o;
    endfunction

    // keep only the write address, write data and write response channels.
    function automatic axi_lite_req_t req_write(input axi_lite_req_t r);
        axi_lite_req_t o;
        o         = '0;
        o.awaddr  = r.awaddr;
        o.awprot  = r.awprot;
        o.awvalid = r.awvalid;
        o.wdata   = r.wdata;
        o.wstrb   = r.wstrb;
        o.wvalid  = r.wvalid;
        o.bready  = r.bready;
        return o;
    endfunction

    function automatic axi_lite_rsp_t rsp_read(input axi_lite_rsp_t r);
        axi_lite_rsp_t o;
        o         = '0;
        o.arready = r.arready;
        o.rvalid  = r.rvalid;
        o.rdata   = r.rdata;
        o.rresp   = r.rresp;
        return o;
    endfunction

    function automatic axi_lite_rsp_t rsp_write(input axi_lite_rsp_t r);
        axi_lite_rsp_t o;
        o         = '0;
        o.awready = r.awready;
        o.wready  = r.wready;
        o.bvalid  = r.bvalid;
        o.bresp   = r.bresp;
        return o;
    endfunction

    // a read needs only arvalid, a write needs both address and data.
    assign m1_rd_req = m1_req.arvalid;
    assign m1_wr_req = m1_req.awvalid && m1_req.wvalid;
    assign m2_rd_req = m2_req.arvalid;
    assign m2_wr_req = m2_req.awvalid && m2_req.wvalid;

    assign m1_sel = (state == M1_READ) || (state == M1_WRITE);
    assign m2_sel = (state == M2_READ) || (state == M2_WRITE);
    assign rd_sel = (state == M1_READ) || (state == M2_READ);
    assign wr_sel = (state == M1_WRITE) || (state == M2_WRITE);

    // response handshakes seen on the slave side of the mux.
    assign rd_done = s_rsp.rvalid && s_req.rready;
    assign wr_done = s_rsp.bvalid && s_req.bready;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (m1_rd_req) begin
                    next_state = M1_READ;
                end else if (m1_wr_req) begin
                    next_state = M1_WRITE;
                end else if (m2_rd_req) begin
                    next_state = M2_READ;
                end else if (m2_wr_req) begin
                    next_state = M2_WRITE;
                end
            end
            M1_READ, M2_READ: begin
                if (rd_done) next_state = IDLE;   // release on the r handshake.
            end
            M1_WRITE, M2_WRITE: begin
                if (wr_done) next_state = IDLE;   // release on the b handshake.
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // routing follows the registered grant only.
    always_comb begin
        s_req    = '0;
        back_rsp = '0;
        m1_rsp   = '0;
        m2_rsp   = '0;

        if (m1_sel) begin
            src_req = m1_req;
        end else if (m2_sel) begin
            src_req = m2_req;
        end else begin
            src_req = '0;
        end

        if (rd_sel) begin
            s_req    = req_read(src_req);
            back_rsp = rsp_read(s_rsp);
        end else if (wr_sel) begin
            s_req    = req_write(src_req);
            back_rsp = rsp_write(s_rsp);
        end

        if (m1_sel) m1_rsp = back_rsp;   // the other master sees all zero.
        if (m2_sel) m2_rsp = back_rsp;
    end

endmodule

//--- axi_interconnect_properties.sv
`timescale 1ns/10ps

module axi_interconnect_properties
    import axi_lite_pkg::*;
(
    input logic          aclk,
    input logic          aresetn,
    input grant_state_t  state,
    input axi_lite_req_t m1_req,
    input axi_lite_rsp_t m1_rsp,
    input axi_lite_req_t m2_req,
    input axi_lite_rsp_t m2_rsp
);

    logic any_req;   // anything the arbiter could grant.

    assign any_req = m1_req.arvalid || (m1_req.awvalid && m1_req.wvalid) ||
                     m2_req.arvalid || (m2_req.awvalid && m2_req.wvalid);

    a_single_response: assert property (@(posedge aclk) disable iff (!aresetn)
        !((m1_rsp.rvalid || m1_rsp.bvalid) && (m2_rsp.rvalid || m2_rsp.bvalid)))
        else $error("both masters see a response valid");

    a_m1_rvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        m1_rsp.rvalid && !m1_req.rready |=> m1_rsp.rvalid)
        else $error("m1 rvalid dropped without rready");

    a_m2_rvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        m2_rsp.rvalid && !m2_req.rready |=> m2_rsp.rvalid)
        else $error("m2 rvalid dropped without rready");

    a_m1_bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        m1_rsp.bvalid && !m1_req.bready |=> m1_rsp.bvalid)
        else $error("m1 bvalid dropped without bready");

    a_m2_bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        m2_rsp.bvalid && !m2_req.bready |=> m2_rsp.bvalid)
        else $error("m2 bvalid dropped without bready");

    // no grant out of idle without a request.
    a_idle_needs_req: assert property (@(posedge aclk) disable iff (!aresetn)
        (state == IDLE) && !any_req |=> (state == IDLE))
        else $error("grant left idle with no request present");

endmodule

bind axi_interconnect axi_interconnect_properties u_properties (
    .aclk    (aclk),
    .aresetn (aresetn),
    .state   (state),
    .m1_req  (m1_req),
    .m1_rsp  (m1_rsp),
    .m2_req  (m2_req),
    .m2_rsp  (m2_rsp)
);

//--- axi_lite_pkg.sv
package axi_lite_pkg;

    // bus geometry.
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int PROT_W = 3;

    // register file geometry.
    localparam int REG_COUNT = 16;
    localparam int REG_IDX_W = $clog2(REG_COUNT);
    localparam int ADDR_LSB  = $clog2(STRB_W);   // byte offset bits inside a word.

    // first byte address past the register file.
    localparam logic [ADDR_W-1:0] REG_SPAN = ADDR_W'(REG_COUNT * STRB_W);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [PROT_W-1:0] prot_t;

    // axi response codes.
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

    // everything a master drives.
    typedef struct packed {
        addr_t awaddr;
        prot_t awprot;
        logic  awvalid;
        data_t wdata;
        strb_t wstrb;
        logic  wvalid;
        logic  bready;
        addr_t araddr;
        prot_t arprot;
        logic  arvalid;
        logic  rready;
    } axi_lite_req_t;

    // everything a slave drives.
    typedef struct packed {
        logic      awready;
        logic      wready;
        logic      bvalid;
        axi_resp_t bresp;
        logic      arready;
        logic      rvalid;
        data_t     rdata;
        axi_resp_t rresp;
    } axi_lite_rsp_t;

    // interconnect grant for one master and one direction at a time.
    typedef enum logic [2:0] {
        IDLE,
        M1_READ,
        M1_WRITE,
        M2_READ,
        M2_WRITE
    } grant_state_t;

endpackage

//--- axi_lite_regfile.sv
`timescale 1ns/10ps

module axi_lite_regfile
    import axi_lite_pkg::*;
(
    input  logic          aclk,
    input  logic          aresetn,
    input  axi_lite_req_t req,
    output axi_lite_rsp_t rsp
);

    data_t regs [REG_COUNT];

    logic [REG_IDX_W-1:0] w_idx;
    logic [REG_IDX_W-1:0] r_idx;
    logic                 w_in_range;
    logic                 r_in_range;

    logic aw_hs;   // address and data accepted together.
    logic ar_hs;

    // pending write response.
    logic      bvalid_q;
    axi_resp_t bresp_q;

    // pending read response.
    logic      rvalid_q;
    data_t     rdata_q;
    axi_resp_t rresp_q;

    assign w_idx      = req.awaddr[ADDR_LSB +: REG_IDX_W];
    assign r_idx      = req.araddr[ADDR_LSB +: REG_IDX_W];
    assign w_in_range = req.awaddr < REG_SPAN;
    assign r_in_range = req.araddr < REG_SPAN;

    // one response slot per direction, so ready waits for it to drain.
    assign aw_hs = req.awvalid && req.wvalid && !bvalid_q;
    assign ar_hs = req.arvalid && !rvalid_q;

    // register array with byte strobes.
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (aw_hs && w_in_range) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (req.wstrb[b]) begin
                    regs[w_idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    // write response channel.
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            bvalid_q <= 1'b0;
        end else if (aw_hs) begin
            bvalid_q <= 1'b1;
        end else if (bvalid_q && req.bready) begin
            bvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (aw_hs) begin
            bresp_q <= w_in_range ? OKAY : SLVERR;
        end
    end

    // read data channel.
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rvalid_q <= 1'b0;
        end else if (ar_hs) begin
            rvalid_q <= 1'b1;
        end else if (rvalid_q && req.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (ar_hs) begin
            if (r_in_range) begin
                rdata_q <= regs[r_idx];
                rresp_q <= OKAY;
            end else begin
                rdata_q <= '0;       // out of range reads as zero.
                rresp_q <= SLVERR;
            end
        end
    end

    always_comb begin
        rsp         = '0;
        rsp.awready = aw_hs;
        rsp.wready  = aw_hs;
        rsp.bvalid  = bvalid_q;
        rsp.bresp   = bresp_q;
        rsp.arready = ar_hs;
        rsp.rvalid  = rvalid_q;
        rsp.rdata   = rdata_q;
        rsp.rresp   = rresp_q;
    end

endmodule

//--- axi_subsystem_top.sv
`timescale 1ns/10ps

module axi_subsystem_top
    import axi_lite_pkg::*;
(
    input  logic          aclk,
    input  logic          aresetn,
    input  axi_lite_req_t m1_req,
    output axi_lite_rsp_t m1_rsp,
    input  axi_lite_req_t m2_req,
    output axi_lite_rsp_t m2_rsp
);

    // shared slave port between arbiter and register file.
    axi_lite_req_t s_req;
    axi_lite_rsp_t s_rsp;

    // two masters share one slave for one transaction per grant.
    axi_interconnect u_interconnect (
        .aclk    (aclk),
        .aresetn (aresetn),
        .m1_req  (m1_req),
        .m1_rsp  (m1_rsp),
        .m2_req  (m2_req),
        .m2_rsp  (m2_rsp),
        .s_req   (s_req),
        .s_rsp   (s_rsp)
    );

    // sixteen word register file.
    axi_lite_regfile u_regfile (
        .aclk    (aclk),
        .aresetn (aresetn),
        .req     (s_req),
        .rsp     (s_rsp)
    );

endmodule

//--- filelist.f
axi_lite_pkg.sv
axi_interconnect.sv
axi_lite_regfile.sv
axi_subsystem_top.sv
axi_interconnect_properties.sv
tb_axi_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Compile the testbench with Verilator and run it; a failing run exits non-zero.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/10ps \
    --top-module tb_axi_subsystem \
    -f filelist.f \
    -o sim_axi_subsystem

./obj_dir/sim_axi_subsystem

//--- tb_axi_subsystem.sv
`timescale 1ns/10ps

module tb_axi_subsystem
    import axi_lite_pkg::*;
();

    localparam int WAIT_LIMIT = 200;   // cycles allowed for any single wait.

    logic          aclk;
    logic          aresetn;
    axi_lite_req_t m_req [1:2];
    axi_lite_rsp_t m_rsp [1:2];
    data_t         ref_regs [REG_COUNT];   // expected register contents.
    int            seed;
    int            cycle;

    axi_subsystem_top DUT (
        .aclk    (aclk),
        .aresetn (aresetn),
        .m1_req  (m_req[1]),
        .m1_rsp  (m_rsp[1]),
        .m2_req  (m_req[2]),
        .m2_rsp  (m_rsp[2])
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    always @(posedge aclk) cycle <= cycle + 1;

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) fail_now($sformatf("ERR %s expected 0x%h actual 0x%h", name, exp, act));
    endtask

    task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
        if (act !== exp) fail_now($sformatf("ERR %s expected 0x%h actual 0x%h", name, exp, act));
    endtask

    // sample once per cycle at mid-cycle where outputs are settled.
    task automatic next_cycle_limited(inout int count, input string what);
        @(negedge aclk);
        count++;
        if (count > WAIT_LIMIT) fail_now($sformatf("timed out waiting for %s", what));
    endtask

    function automatic bit in_range(input addr_t addr);
        return addr < REG_COUNT * 4;
    endfunction

    function automatic axi_resp_t expect_resp(input addr_t addr);
        return in_range(addr) ? OKAY : SLVERR;
    endfunction

    function automatic data_t expect_rdata(input addr_t addr);
        return in_range(addr) ? ref_regs[int'(addr >> 2)] : '0;
    endfunction

    // each strobe bit selects one byte lane of the new word.
    function automatic void model_write(input addr_t addr, input data_t data, input strb_t strb);
        data_t mask;
        int    idx;
        if (in_range(addr)) begin
            idx = int'(addr >> 2);
            for (int b = 0; b < STRB_W; b++) mask[8*b +: 8] = {8{strb[b]}};
            ref_regs[idx] = (data & mask) | (ref_regs[idx] & ~mask);
        end
    endfunction

    task automatic axi_write(input int m, input addr_t addr, input data_t data, input strb_t strb,
                             output axi_resp_t resp);
        int count;
        @(posedge aclk);
        #1;
        m_req[m].awaddr  = addr;
        m_req[m].wdata   = data;
        m_req[m].wstrb   = strb;
        m_req[m].awvalid = 1'b1;
        m_req[m].wvalid  = 1'b1;
        m_req[m].bready  = 1'b1;
        count = 0;
        do next_cycle_limited(count, "awready and wready");
        while (!(m_rsp[m].awready && m_rsp[m].wready));
        @(posedge aclk);
        #1;
        m_req[m].awvalid = 1'b0;
        m_req[m].wvalid  = 1'b0;
        count = 0;
        do next_cycle_limited(count, "bvalid"); while (!m_rsp[m].bvalid);
        resp = m_rsp[m].bresp;
        @(posedge aclk);
        #1;
        m_req[m].bready = 1'b0;
    endtask

    // hold is the number of cycles rready stays low after rvalid shows up.
    task automatic axi_read(input int m, input addr_t addr, input int hold,
                            output data_t data, output axi_resp_t resp);
        int count;
        @(posedge aclk);
        #1;
        m_req[m].araddr  = addr;
        m_req[m].arvalid = 1'b1;
        m_req[m].rready  = (hold == 0);
        count = 0;
        do next_cycle_limited(count, "arready"); while (!m_rsp[m].arready);
        @(posedge aclk);
        #1;
        m_req[m].arvalid = 1'b0;
        count = 0;
        do next_cycle_limited(count, "rvalid"); while (!m_rsp[m].rvalid);
        data = m_rsp[m].rdata;
        resp = m_rsp[m].rresp;
        if (hold > 0) begin
            repeat (hold) @(posedge aclk);
            #1;
            m_req[m].rready = 1'b1;
            @(negedge aclk);
            if (!m_rsp[m].rvalid) fail_now("rvalid dropped before rready was raised");
        end
        @(posedge aclk);
        #1;
        m_req[m].rready = 1'b0;
    endtask

    task automatic read_and_check(input int m, input addr_t addr);
        data_t     rd;
        axi_resp_t rs;
        axi_read(m, addr, 0, rd, rs);
        check_resp($sformatf("m%0d_rsp.rresp", m), expect_resp(addr), rs);
        check_data($sformatf("m%0d_rsp.rdata", m), expect_rdata(addr), rd);
    endtask

    task automatic write_and_check(input int m, input addr_t addr, input data_t data,
                                   input strb_t strb);
        axi_resp_t rs;
        axi_write(m, addr, data, strb, rs);
        check_resp($sformatf("m%0d_rsp.bresp", m), expect_resp(addr), rs);
        model_write(addr, data, strb);
    endtask

    task automatic after_reset_values();
        @(negedge aclk);
        for (int m = 1; m <= 2; m++) begin
            if ({m_rsp[m].awready, m_rsp[m].wready, m_rsp[m].bvalid, m_rsp[m].arready,
                 m_rsp[m].rvalid} !== 5'b0)
                fail_now($sformatf("ERR m%0d_rsp handshake bits expected 0x00 actual 0x%h", m,
                         {m_rsp[m].awready, m_rsp[m].wready, m_rsp[m].bvalid,
                          m_rsp[m].arready, m_rsp[m].rvalid}));
        end
        for (int i = 0; i < REG_COUNT; i++) read_and_check(1, addr_t'(i * 4));
    endtask

    task automatic full_strobe_writes();
        for (int i = 0; i < REG_COUNT; i++) write_and_check(i < REG_COUNT / 2 ? 1 : 2,
                                                            addr_t'(i * 4), $random(seed), '1);
        // read back through the master that did not write.
        for (int i = 0; i < REG_COUNT; i++) read_and_check(i < REG_COUNT / 2 ? 2 : 1,
                                                           addr_t'(i * 4));
    endtask

    task automatic partial_strobe_writes();
        strb_t strobes [5];
        strobes[0] = 4'b0001;
        strobes[1] = 4'b0110;
        strobes[2] = 4'b1000;
        strobes[3] = 4'b1010;
        strobes[4] = 4'b0000;
        for (int k = 0; k < 5; k++) begin
            write_and_check(k % 2 + 1, addr_t'((3 + 2 * k) * 4), $random(seed), strobes[k]);
            read_and_check(2 - k % 2, addr_t'((3 + 2 * k) * 4));
        end
    endtask

    task automatic out_of_range_access();
        write_and_check(2, 32'h0000_0040, $random(seed), '1);
        write_and_check(1, 32'h1000_0000, $random(seed), 4'b0101);
        read_and_check(2, 32'h0000_0040);
        read_and_check(1, 32'hffff_fffc);
        for (int i = 0; i < REG_COUNT; i++) read_and_check(1, addr_t'(i * 4));
    endtask

    task automatic read_contention();
        data_t     d1;
        data_t     d2;
        axi_resp_t r1;
        axi_resp_t r2;
        bit        m1_accepted;
        bit        m2_finished;
        int        count;
        m1_accepted = 1'b0;
        m2_finished = 1'b0;
        count = 0;
        fork
            axi_read(1, 32'h08, 4, d1, r1);   // m1 stalls its read data.
            begin
                axi_read(2, 32'h24, 0, d2, r2);
                m2_finished = 1'b1;
            end
            while (!m2_finished) begin
                next_cycle_limited(count, "the second read to finish");
                if (m_rsp[1].rvalid && m_req[1].rready) m1_accepted = 1'b1;
                if (m_rsp[2].rvalid && !m1_accepted)
                    fail_now("m2 saw rvalid before m1 took its data");
            end
        join
        check_resp("m1_rsp.rresp", OKAY, r1);
        check_data("m1_rsp.rdata", expect_rdata(32'h08), d1);
        check_resp("m2_rsp.rresp", OKAY, r2);
        check_data("m2_rsp.rdata", expect_rdata(32'h24), d2);
    endtask

    task automatic write_read_contention();
        data_t     wd;
        data_t     rd;
        axi_resp_t rr;
        axi_resp_t br;
        int        t_read;
        int        t_write;
        wd = $random(seed);
        fork
            begin
                axi_write(2, 32'h18, wd, '1, br);
                t_write = cycle;
            end
            begin
                axi_read(1, 32'h18, 0, rd, rr);
                t_read = cycle;
            end
        join
        if (t_read >= t_write) fail_now("m2 write completed before the m1 read");
        check_resp("m1_rsp.rresp", OKAY, rr);
        check_data("m1_rsp.rdata", expect_rdata(32'h18), rd);   // still the old value.
        check_resp("m2_rsp.bresp", OKAY, br);
        model_write(32'h18, wd, '1);
        read_and_check(1, 32'h18);
    endtask

    initial begin
        seed     = 89050;
        aresetn  = 1'b0;
        m_req[1] = '0;
        m_req[2] = '0;
        for (int i = 0; i < REG_COUNT; i++) ref_regs[i] = '0;
        repeat (8) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        after_reset_values();
        full_strobe_writes();
        partial_strobe_writes();
        out_of_range_access();
        read_contention();
        write_read_contention();
        $display("*** PASSED ***");
        $finish;
    end

endmodule
